// ==== Bender.yml ====
package:
  name: rv_frontend

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_decoder.sv
  - verilog/rv_decode_stage.sv
  - verilog/rv_fetch.sv
  - verilog/rv_frontend.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_rv_frontend.sv

// ==== list.f ====
+incdir+verif
verilog/rv_pkg.sv
verilog/rv_decoder.sv
verilog/rv_decode_stage.sv
verilog/rv_fetch.sv
verilog/rv_frontend.sv
verif/tb_rv_frontend.sv

// ==== verif/tb_ref_decode.svh ====
`ifndef tb_ref_decode_svh
`define tb_ref_decode_svh

// Decoded fields as the issue stage sees them, without the PC
typedef struct packed {
    rv_pkg::alu_op_e      op;
    logic                 option;
    logic                 truncate;
    rv_pkg::op_type_e     op_type;
    rv_pkg::br_type_e     br_type;
    logic                 mem_sign;
    logic [1:0]           mem_width;
    rv_pkg::operand_sel_e operand1;
    rv_pkg::operand_sel_e operand2;
    logic [63:0]          imm;
    logic                 legal;
    logic                 wb_en;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [4:0]           rd;
} dec_fields_t;

logic [31:0] lfsr_state = 32'hf6ca;

// Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Every random bit costs one LFSR step
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        r = {r[30:0], lfsr_state[0]};
    end
    return r;
endfunction

// Expected decode of one word, written from the RV64I encoding rules
function automatic dec_fields_t ref_decode(input logic [31:0] w);
    dec_fields_t e;
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    e = '0;
    e.rs1 = w[19:15];
    e.rs2 = w[24:20];
    e.rd = w[11:7];
    e.op_type = rv_pkg::alu;
    case (w[6:0])
        rv_pkg::opc_op_imm, rv_pkg::opc_op_imm_32: begin
            e.op = rv_pkg::alu_op_e'(f3);
            e.operand2 = rv_pkg::sel_imm;
            e.imm = $signed(w[31:20]);
            e.option = (f3 == 3'd5) && w[30];
            e.truncate = (w[6:0] == rv_pkg::opc_op_imm_32);
            if (!e.truncate) begin
                // 64-bit shifts keep bit 25 for the sixth shamt bit
                e.legal = !(f3 == 3'd1 && w[31:26] != 6'h00)
                          && !(f3 == 3'd5 && w[31:26] != 6'h00 && w[31:26] != 6'h10);
            end else begin
                e.legal = (f3 == 3'd0) || (f3 == 3'd1 && f7 == 7'h00)
                          || (f3 == 3'd5 && (f7 == 7'h00 || f7 == 7'h20));
            end
        end
        rv_pkg::opc_op, rv_pkg::opc_op_32: begin
            e.op = rv_pkg::alu_op_e'(f3);
            e.option = w[30];
            e.truncate = (w[6:0] == rv_pkg::opc_op_32);
            if (!e.truncate) begin
                e.legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end else begin
                e.legal = ((f3 == 3'd0 || f3 == 3'd5) && (f7 == 7'h00 || f7 == 7'h20))
                          || (f3 == 3'd1 && f7 == 7'h00);
            end
        end
        rv_pkg::opc_lui, rv_pkg::opc_auipc: begin
            e.operand1 = (w[5]) ? rv_pkg::sel_zero : rv_pkg::sel_pc;
            e.operand2 = rv_pkg::sel_imm;
            e.imm = $signed({w[31:12], 12'h000});
            e.legal = 1'b1;
        end
        rv_pkg::opc_jal: begin
            e.op_type = rv_pkg::jump;
            e.br_type = rv_pkg::br_jal;
            e.operand1 = rv_pkg::sel_pc;
            e.operand2 = rv_pkg::sel_zero;
            e.imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
            e.legal = 1'b1;
        end
        rv_pkg::opc_jalr: begin
            e.op_type = rv_pkg::jump;
            e.br_type = rv_pkg::br_jalr;
            e.operand1 = rv_pkg::sel_pc;
            e.operand2 = rv_pkg::sel_zero;
            e.imm = $signed(w[31:20]);
            e.legal = (f3 == 3'd0);
        end
        rv_pkg::opc_branch: begin
            // The compare condition travels on op
            e.op_type = rv_pkg::branch;
            e.op = rv_pkg::alu_op_e'(f3);
            e.br_type = rv_pkg::br_cond;
            e.imm = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
            e.legal = (f3 != 3'd2) && (f3 != 3'd3);
        end
        rv_pkg::opc_load: begin
            e.op_type = rv_pkg::load;
            e.operand2 = rv_pkg::sel_imm;
            e.imm = $signed(w[31:20]);
            e.mem_width = f3[1:0];
            e.mem_sign = !f3[2];
            e.legal = (f3 != 3'd7);
        end
        rv_pkg::opc_store: begin
            e.op_type = rv_pkg::store;
            e.operand2 = rv_pkg::sel_imm;
            e.imm = $signed({w[31:25], w[11:7]});
            e.mem_width = f3[1:0];
            e.legal = (f3 < 3'd4);
        end
        default: e.legal = 1'b0;
    endcase
    if (!e.legal) begin
        e.op_type = rv_pkg::illegal;
    end
    // Only ALU results, link values and loaded data reach a real destination register
    e.wb_en = e.legal && e.rd != 5'd0
              && (e.op_type == rv_pkg::alu || e.op_type == rv_pkg::jump
                  || e.op_type == rv_pkg::load);
    return e;
endfunction

// One random instruction word, mostly legal, from every opcode class
function automatic logic [31:0] gen_instr();
    logic [31:0] w;
    logic [31:0] r;
    logic [3:0] pick;
    r = rand_bits(4);
    pick = r[3:0];
    r = rand_bits(25);
    w = {r[24:0], 7'b0000000};
    case (pick)
        4'd0: w[6:0] = rv_pkg::opc_op_imm;
        4'd1: w[6:0] = rv_pkg::opc_op;
        4'd2: w[6:0] = rv_pkg::opc_op_imm_32;
        4'd3: w[6:0] = rv_pkg::opc_op_32;
        4'd4: w[6:0] = rv_pkg::opc_lui;
        4'd5: w[6:0] = rv_pkg::opc_auipc;
        4'd6: w[6:0] = rv_pkg::opc_jal;
        4'd7: w[6:0] = rv_pkg::opc_jalr;
        4'd8: w[6:0] = rv_pkg::opc_branch;
        4'd9: w[6:0] = rv_pkg::opc_load;
        4'd10: w[6:0] = rv_pkg::opc_store;
        // Fence, system and atomic encodings are outside the decoded set
        4'd11: w[6:0] = 7'b0001111;
        4'd12: w[6:0] = 7'b1110011;
        4'd13: w[6:0] = 7'b0101111;
        default: w[1:0] = 2'b01;
    endcase
    // Shape funct7 so that most register forms and shifts are legal
    if (pick == 4'd1 || pick == 4'd3 || ((pick == 4'd0 || pick == 4'd2) && w[13:12] == 2'b01)) begin
        r = rand_bits(1);
        w[31:25] = r[0] ? 7'h20 : 7'h00;
    end
    if (pick == 4'd7) begin
        w[14:12] = 3'd0;
    end
    return w;
endfunction

`endif

// ==== verif/tb_rv_frontend.sv ====
`timescale 1ns/1ps

module tb_rv_frontend;

    localparam int num_transfers = 300;
    // Up to 12 cycles per transfer with bus waits and stalls, plus margin
    localparam int max_cycles = num_transfers * 12 + 400;
    localparam int mem_words = 2048;
    localparam int flush_spacing = 100;
    localparam logic [63:0] redirect_first = 64'h8000_0800;
    localparam logic [63:0] redirect_second = 64'h8000_1000;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    logic [63:0] redirect_pc;
    logic ibus_cyc;
    logic ibus_stb;
    logic [63:0] ibus_adr;
    logic [31:0] ibus_dat_r;
    logic ibus_ack;
    logic [63:0] dec_pc;
    rv_pkg::alu_op_e dec_op;
    logic dec_option;
    logic dec_truncate;
    rv_pkg::op_type_e dec_op_type;
    rv_pkg::br_type_e dec_br_type;
    logic dec_mem_sign;
    logic [1:0] dec_mem_width;
    rv_pkg::operand_sel_e dec_operand1;
    rv_pkg::operand_sel_e dec_operand2;
    logic [63:0] dec_imm;
    logic dec_wb_en;
    logic dec_legal;
    logic [4:0] dec_rs1;
    logic [4:0] dec_rs2;
    logic [4:0] dec_rd;
    logic dec_valid;
    logic dec_ready;

    `include "tb_ref_decode.svh"

    logic [31:0] imem [0:mem_words-1];
    logic [63:0] exp_pcs[$];
    int value_errors = 0;
    int other_errors = 0;
    int transfers = 0;
    int cycles = 0;
    int reset_cycles = 0;
    int wait_left = 0;
    int flushes_done = 0;
    bit in_cycle = 1'b0;
    bit first_cycle = 1'b1;
    bit stalled = 1'b0;
    logic [63:0] cycle_adr;
    logic [63:0] held_pc;
    dec_fields_t held;

    rv_frontend u_rv_frontend (.*);

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Memory covers 8 KiB starting at the reset PC
    function automatic logic [31:0] read_word(input logic [63:0] adr);
        assert (adr[63:13] == rv_pkg::reset_pc[63:13]) else begin
            other_errors++;
            $display("Address %h is outside the instruction memory at %0t ns", adr, $time);
            return 32'h0;
        end
        return imem[adr[12:2]];
    endfunction

    function automatic dec_fields_t observed();
        dec_fields_t o;
        o.op = dec_op;
        o.option = dec_option;
        o.truncate = dec_truncate;
        o.op_type = dec_op_type;
        o.br_type = dec_br_type;
        o.mem_sign = dec_mem_sign;
        o.mem_width = dec_mem_width;
        o.operand1 = dec_operand1;
        o.operand2 = dec_operand2;
        o.imm = dec_imm;
        o.legal = dec_legal;
        o.wb_en = dec_wb_en;
        o.rs1 = dec_rs1;
        o.rs2 = dec_rs2;
        o.rd = dec_rd;
        return o;
    endfunction

    // Illegal words only promise legal, op_type and wb_en
    task automatic compare_fields(input dec_fields_t got, input dec_fields_t exp, input bit full);
        check_value("dec_legal", got.legal, exp.legal);
        check_value("dec_op_type", got.op_type, exp.op_type);
        check_value("dec_wb_en", got.wb_en, exp.wb_en);
        if (full) begin
            check_value("dec_op", got.op, exp.op);
            check_value("dec_option", got.option, exp.option);
            check_value("dec_truncate", got.truncate, exp.truncate);
            check_value("dec_br_type", got.br_type, exp.br_type);
            check_value("dec_mem_sign", got.mem_sign, exp.mem_sign);
            check_value("dec_mem_width", got.mem_width, exp.mem_width);
            check_value("dec_operand1", got.operand1, exp.operand1);
            check_value("dec_operand2", got.operand2, exp.operand2);
            check_value("dec_imm", got.imm, exp.imm);
            check_value("dec_rs1", got.rs1, exp.rs1);
            check_value("dec_rs2", got.rs2, exp.rs2);
            check_value("dec_rd", got.rd, exp.rd);
        end
    endtask

    // Wishbone slave with a random wait of 0 to 3 cycles before ack
    task automatic drive_bus();
        logic [31:0] r;
        assert (!ibus_stb || ibus_cyc) else begin
            other_errors++;
            $display("Bus stb is high without cyc at %0t ns", $time);
        end
        if (ibus_ack) begin
            // The DUT closed the cycle on the edge that saw ack
            assert (!ibus_cyc && !ibus_stb) else begin
                other_errors++;
                $display("Bus cycle stayed open after ack at %0t ns", $time);
            end
            ibus_ack = 1'b0;
        end else begin
            assert (ibus_stb || !in_cycle) else begin
                other_errors++;
                in_cycle = 1'b0;
                $display("Bus stb fell before ack at %0t ns", $time);
            end
            if (ibus_stb) begin
                if (!in_cycle) begin
                    in_cycle = 1'b1;
                    cycle_adr = ibus_adr;
                    r = rand_bits(2);
                    wait_left = r[1:0];
                    if (first_cycle) begin
                        first_cycle = 1'b0;
                        check_value("ibus_adr", ibus_adr, rv_pkg::reset_pc);
                    end
                end else begin
                    check_value("ibus_adr", ibus_adr, cycle_adr);
                end
                if (wait_left == 0) begin
                    ibus_ack = 1'b1;
                    ibus_dat_r = read_word(ibus_adr);
                    in_cycle = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    endtask

    // All inputs change 1 ns after the rising edge, reset included
    always @(posedge clk) begin
        #1;
        if (rst) begin
            reset_cycles++;
            if (reset_cycles == 8) begin
                rst = 1'b0;
            end
        end else begin
            cycles++;
            drive_bus();
            flush = 1'b0;
            dec_ready = (rand_bits(2) != 0);
            // The first flush finds fetch holding a finished word
            // The second one lands while a bus cycle is open
            if (flushes_done < 2 && transfers >= (flushes_done + 1) * flush_spacing
                    && (flushes_done == 0 ? !ibus_stb : ibus_stb)) begin
                flush = 1'b1;
                dec_ready = 1'b0;
                redirect_pc = (flushes_done == 0) ? redirect_first : redirect_second;
                flushes_done++;
                exp_pcs.delete();
                exp_pcs.push_back(redirect_pc);
            end
        end
    end

    task automatic check_transfer();
        logic [63:0] pc;
        dec_fields_t e;
        pc = exp_pcs.pop_front();
        exp_pcs.push_back(pc + 64'd4);
        check_value("dec_pc", dec_pc, pc);
        e = ref_decode(read_word(pc));
        compare_fields(observed(), e, e.legal);
        transfers++;
    endtask

    // Outputs and inputs are both settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (stalled) begin
                assert (dec_valid) else begin
                    other_errors++;
                    $display("dec_valid fell while dec_ready was low at %0t ns", $time);
                end
                check_value("dec_pc", dec_pc, held_pc);
                compare_fields(observed(), held, 1'b1);
            end
            if (dec_valid && dec_ready && !flush) begin
                check_transfer();
            end
            stalled = dec_valid && !dec_ready && !flush;
            held = observed();
            held_pc = dec_pc;
        end
    end

    initial begin
        int i;
        rst = 1'b1;
        flush = 1'b0;
        redirect_pc = '0;
        ibus_dat_r = '0;
        ibus_ack = 1'b0;
        dec_ready = 1'b0;
        for (i = 0; i < mem_words; i++) begin
            imem[i] = gen_instr();
        end
        exp_pcs.push_back(rv_pkg::reset_pc);
        wait (!rst);
        @(negedge clk);
        assert (!ibus_cyc && !ibus_stb && !dec_valid) else begin
            other_errors++;
            $display("Bus or decode output active right after reset at %0t ns", $time);
        end
        wait (transfers >= num_transfers || cycles >= max_cycles);
        if (transfers < num_transfers) begin
            other_errors++;
            $display("Timeout after %0d cycles with %0d of %0d transfers done",
                     cycles, transfers, num_transfers);
        end
        $display("Transfers %0d, flushes %0d, value errors %0d, other errors %0d",
                 transfers, flushes_done, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/rv_decode_stage.sv ====
`timescale 1ns/1ps

module rv_decode_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic [rv_pkg::xlen-1:0] fch_pc,
    input  logic [rv_pkg::ilen-1:0] fch_instr,
    input  logic                    fch_valid,
    output logic                    fch_ready,
    output logic [rv_pkg::xlen-1:0] dec_pc,
    output rv_pkg::alu_op_e         dec_op,
    output logic                    dec_option,
    output logic                    dec_truncate,
    output rv_pkg::op_type_e        dec_op_type,
    output rv_pkg::br_type_e        dec_br_type,
    output logic                    dec_mem_sign,
    output logic [1:0]              dec_mem_width,
    output rv_pkg::operand_sel_e    dec_operand1,
    output rv_pkg::operand_sel_e    dec_operand2,
    output logic [rv_pkg::xlen-1:0] dec_imm,
    output logic                    dec_wb_en,
    output logic                    dec_legal,
    output logic [4:0]              dec_rs1,
    output logic [4:0]              dec_rs2,
    output logic [4:0]              dec_rd,
    output logic                    dec_valid,
    input  logic                    dec_ready
);

    rv_pkg::alu_op_e      du_op;
    rv_pkg::op_type_e     du_op_type;
    rv_pkg::br_type_e     du_br_type;
    rv_pkg::operand_sel_e du_operand1;
    rv_pkg::operand_sel_e du_operand2;
    logic du_option;
    logic du_truncate;
    logic du_mem_sign;
    logic [1:0] du_mem_width;
    logic [rv_pkg::xlen-1:0] du_imm;
    logic du_legal;
    logic du_wb_en;
    logic [4:0] du_rs1;
    logic [4:0] du_rs2;
    logic [4:0] du_rd;
    logic take_in;

    rv_decoder u_rv_decoder (
        .instr(fch_instr), .op(du_op), .option(du_option), .truncate(du_truncate),
        .op_type(du_op_type), .br_type(du_br_type), .mem_sign(du_mem_sign),
        .mem_width(du_mem_width), .operand1(du_operand1), .operand2(du_operand2),
        .imm(du_imm), .legal(du_legal), .wb_en(du_wb_en),
        .rs1(du_rs1), .rs2(du_rs2), .rd(du_rd)
    );

    // The output register can take a new word when empty or when it drains this cycle
    assign fch_ready = !dec_valid || dec_ready;
    assign take_in   = fch_valid && fch_ready;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            dec_valid <= 1'b0;
        end else if (take_in) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    // Payload is only written on a transfer, so it holds while stalled
    always_ff @(posedge clk) begin
        if (take_in) begin
            dec_pc        <= fch_pc;
            dec_op        <= du_op;
            dec_option    <= du_option;
            dec_truncate  <= du_truncate;
            dec_op_type   <= du_op_type;
            dec_br_type   <= du_br_type;
            dec_mem_sign  <= du_mem_sign;
            dec_mem_width <= du_mem_width;
            dec_operand1  <= du_operand1;
            dec_operand2  <= du_operand2;
            dec_imm       <= du_imm;
            dec_legal     <= du_legal;
            dec_wb_en     <= du_wb_en;
            dec_rs1       <= du_rs1;
            dec_rs2       <= du_rs2;
            dec_rd        <= du_rd;
        end
    end

    // A stalled instruction stays offered with every field unchanged
    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready && !flush |=> dec_valid && $stable({dec_pc, dec_op,
        dec_option, dec_truncate, dec_op_type, dec_br_type, dec_mem_sign, dec_mem_width,
        dec_operand1, dec_operand2, dec_imm, dec_legal, dec_wb_en, dec_rs1, dec_rs2, dec_rd}));

    // Neither the fetch holding register nor this one offers a squashed word after a flush
    a_flush_clears: assert property (@(posedge clk) disable iff (rst)
        flush |=> !dec_valid && !fch_valid);

endmodule

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/1ps

module rv_decoder (
    input  logic [rv_pkg::ilen-1:0] instr,
    output rv_pkg::alu_op_e         op,
    output logic                    option,
    output logic                    truncate,
    output rv_pkg::op_type_e        op_type,
    output rv_pkg::br_type_e        br_type,
    output logic                    mem_sign,
    output logic [1:0]              mem_width,
    output rv_pkg::operand_sel_e    operand1,
    output rv_pkg::operand_sel_e    operand2,
    output logic [rv_pkg::xlen-1:0] imm,
    output logic                    legal,
    output logic                    wb_en,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [rv_pkg::xlen-1:0] imm_i;
    logic [rv_pkg::xlen-1:0] imm_s;
    logic [rv_pkg::xlen-1:0] imm_b;
    logic [rv_pkg::xlen-1:0] imm_u;
    logic [rv_pkg::xlen-1:0] imm_j;
    logic f7_zero;
    logic f7_alt;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Register numbers sit at fixed positions in every format
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // All immediates are sign extended from bit 31
    assign imm_i = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(rv_pkg::xlen-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(rv_pkg::xlen-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {{(rv_pkg::xlen-32){instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{(rv_pkg::xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // Only funct7 of zero or the sub/sra pattern is defined
    assign f7_zero = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);

    always_comb begin
        op        = rv_pkg::add;
        option    = 1'b0;
        truncate  = 1'b0;
        op_type   = rv_pkg::illegal;
        br_type   = rv_pkg::br_none;
        mem_sign  = 1'b0;
        mem_width = 2'b00;
        operand1  = rv_pkg::sel_reg;
        operand2  = rv_pkg::sel_reg;
        imm       = '0;
        legal     = 1'b0;
        case (opcode)
            rv_pkg::opc_op_imm: begin
                op_type  = rv_pkg::alu;
                op       = rv_pkg::alu_op_e'(funct3);
                operand2 = rv_pkg::sel_imm;
                imm      = imm_i;
                // RV64 shifts take a 6-bit shamt, so only bits 31:26 are funct bits
                if (funct3 == 3'b001) begin
                    legal = (instr[31:26] == 6'b000000);
                end else if (funct3 == 3'b101) begin
                    legal  = (instr[31:26] == 6'b000000) || (instr[31:26] == 6'b010000);
                    option = instr[30];
                end else begin
                    legal = 1'b1;
                end
            end
            rv_pkg::opc_op: begin
                op_type = rv_pkg::alu;
                op      = rv_pkg::alu_op_e'(funct3);
                option  = instr[30];
                // The alternate funct7 is only meaningful for sub and sra
                legal   = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            rv_pkg::opc_op_imm_32: begin
                op_type  = rv_pkg::alu;
                op       = rv_pkg::alu_op_e'(funct3);
                truncate = 1'b1;
                operand2 = rv_pkg::sel_imm;
                imm      = imm_i;
                case (funct3)
                    3'b000: legal = 1'b1;
                    3'b001: legal = f7_zero;
                    3'b101: begin
                        legal  = f7_zero || f7_alt;
                        option = instr[30];
                    end
                    default: legal = 1'b0;
                endcase
            end
            rv_pkg::opc_op_32: begin
                op_type  = rv_pkg::alu;
                op       = rv_pkg::alu_op_e'(funct3);
                truncate = 1'b1;
                option   = instr[30];
                case (funct3)
                    3'b000, 3'b101: legal = f7_zero || f7_alt;
                    3'b001:         legal = f7_zero;
                    default:        legal = 1'b0;
                endcase
            end
            rv_pkg::opc_lui: begin
                op_type  = rv_pkg::alu;
                operand1 = rv_pkg::sel_zero;
                operand2 = rv_pkg::sel_imm;
                imm      = imm_u;
                legal    = 1'b1;
            end
            rv_pkg::opc_auipc: begin
                op_type  = rv_pkg::alu;
                operand1 = rv_pkg::sel_pc;
                operand2 = rv_pkg::sel_imm;
                imm      = imm_u;
                legal    = 1'b1;
            end
            rv_pkg::opc_jal, rv_pkg::opc_jalr: begin
                // The ALU only forms the link value, the target is added downstream
                op_type  = rv_pkg::jump;
                operand1 = rv_pkg::sel_pc;
                operand2 = rv_pkg::sel_zero;
                br_type  = (opcode == rv_pkg::opc_jal) ? rv_pkg::br_jal : rv_pkg::br_jalr;
                imm      = (opcode == rv_pkg::opc_jal) ? imm_j : imm_i;
                legal    = (opcode == rv_pkg::opc_jal) || (funct3 == 3'b000);
            end
            rv_pkg::opc_branch: begin
                // funct3 rides on op as the compare condition
                op_type = rv_pkg::branch;
                op      = rv_pkg::alu_op_e'(funct3);
                br_type = rv_pkg::br_cond;
                imm     = imm_b;
                legal   = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            rv_pkg::opc_load: begin
                op_type   = rv_pkg::load;
                operand2  = rv_pkg::sel_imm;
                imm       = imm_i;
                mem_width = funct3[1:0];
                mem_sign  = ~funct3[2];
                legal     = (funct3 != 3'b111);
            end
            rv_pkg::opc_store: begin
                op_type   = rv_pkg::store;
                operand2  = rv_pkg::sel_imm;
                imm       = imm_s;
                mem_width = funct3[1:0];
                legal     = ~funct3[2];
            end
            default: legal = 1'b0;
        endcase
        if (!legal) begin
            op_type = rv_pkg::illegal;
        end
    end

    // Stores, branches, x0 targets and illegal words never write back
    assign wb_en = legal && (op_type != rv_pkg::store) && (op_type != rv_pkg::branch)
                   && (rd != 5'd0);

endmodule

// ==== verilog/rv_fetch.sv ====
`timescale 1ns/1ps

module rv_fetch (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic [rv_pkg::xlen-1:0] redirect_pc,
    output logic                    ibus_cyc,
    output logic                    ibus_stb,
    output logic [rv_pkg::xlen-1:0] ibus_adr,
    input  logic [rv_pkg::ilen-1:0] ibus_dat_r,
    input  logic                    ibus_ack,
    output logic [rv_pkg::xlen-1:0] fch_pc,
    output logic [rv_pkg::ilen-1:0] fch_instr,
    output logic                    fch_valid,
    input  logic                    fch_ready
);

    // Drop means the open cycle belongs to a squashed path
    typedef enum logic [1:0] {
        idle = 2'd0,
        bus  = 2'd1,
        drop = 2'd2
    } fetch_state_e;

    fetch_state_e state;
    logic [rv_pkg::xlen-1:0] pc;
    logic start;
    logic accept;

    // Start only when the holding register is empty or emptying this cycle
    assign start  = (state == idle) && !flush && (!fch_valid || fch_ready);
    assign accept = (state == bus) && ibus_ack && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            ibus_cyc  <= 1'b0;
            ibus_stb  <= 1'b0;
            fch_valid <= 1'b0;
            pc        <= rv_pkg::reset_pc;
        end else begin
            if (fch_valid && fch_ready) begin
                fch_valid <= 1'b0;
            end
            case (state)
                idle: begin
                    if (start) begin
                        state    <= bus;
                        ibus_cyc <= 1'b1;
                        ibus_stb <= 1'b1;
                    end
                end
                bus, drop: begin
                    if (ibus_ack) begin
                        // Cycle ends, cyc and stb fall in the cycle after ack
                        state    <= idle;
                        ibus_cyc <= 1'b0;
                        ibus_stb <= 1'b0;
                    end else if (flush) begin
                        state <= drop;
                    end
                end
                default: state <= idle;
            endcase
            if (accept) begin
                fch_valid <= 1'b1;
                pc        <= pc + 64'd4;
            end
            // A redirect overrides everything else and discards the held word
            if (flush) begin
                fch_valid <= 1'b0;
                pc        <= redirect_pc;
            end
        end
    end

    // Address is latched at cycle start so a redirect cannot disturb an open cycle
    always_ff @(posedge clk) begin
        if (start) begin
            ibus_adr <= pc;
        end
        if (accept) begin
            fch_pc    <= ibus_adr;
            fch_instr <= ibus_dat_r;
        end
    end

    a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
        ibus_stb |-> ibus_cyc);

    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        ibus_stb && !ibus_ack |=> ibus_stb && $stable(ibus_adr));

    // Catches a misaligned redirect coming from outside the front end
    a_adr_align: assert property (@(posedge clk) disable iff (rst)
        ibus_stb |-> ibus_adr[1:0] == 2'b00);

endmodule

// ==== verilog/rv_frontend.sv ====
`timescale 1ns/1ps

module rv_frontend (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic [rv_pkg::xlen-1:0] redirect_pc,
    output logic                    ibus_cyc,
    output logic                    ibus_stb,
    output logic [rv_pkg::xlen-1:0] ibus_adr,
    input  logic [rv_pkg::ilen-1:0] ibus_dat_r,
    input  logic                    ibus_ack,
    output logic [rv_pkg::xlen-1:0] dec_pc,
    output rv_pkg::alu_op_e         dec_op,
    output logic                    dec_option,
    output logic                    dec_truncate,
    output rv_pkg::op_type_e        dec_op_type,
    output rv_pkg::br_type_e        dec_br_type,
    output logic                    dec_mem_sign,
    output logic [1:0]              dec_mem_width,
    output rv_pkg::operand_sel_e    dec_operand1,
    output rv_pkg::operand_sel_e    dec_operand2,
    output logic [rv_pkg::xlen-1:0] dec_imm,
    output logic                    dec_wb_en,
    output logic                    dec_legal,
    output logic [4:0]              dec_rs1,
    output logic [4:0]              dec_rs2,
    output logic [4:0]              dec_rd,
    output logic                    dec_valid,
    input  logic                    dec_ready
);

    // Holding register of fetch feeding the decode stage
    logic [rv_pkg::xlen-1:0] fch_pc;
    logic [rv_pkg::ilen-1:0] fch_instr;
    logic fch_valid;
    logic fch_ready;

    rv_fetch u_rv_fetch (
        .clk(clk), .rst(rst), .flush(flush), .redirect_pc(redirect_pc),
        .ibus_cyc(ibus_cyc), .ibus_stb(ibus_stb), .ibus_adr(ibus_adr),
        .ibus_dat_r(ibus_dat_r), .ibus_ack(ibus_ack),
        .fch_pc(fch_pc), .fch_instr(fch_instr), .fch_valid(fch_valid), .fch_ready(fch_ready)
    );

    // Flush reaches both stages on the same edge
    rv_decode_stage u_rv_decode_stage (
        .clk(clk), .rst(rst), .flush(flush),
        .fch_pc(fch_pc), .fch_instr(fch_instr), .fch_valid(fch_valid), .fch_ready(fch_ready),
        .dec_pc(dec_pc), .dec_op(dec_op), .dec_option(dec_option),
        .dec_truncate(dec_truncate), .dec_op_type(dec_op_type), .dec_br_type(dec_br_type),
        .dec_mem_sign(dec_mem_sign), .dec_mem_width(dec_mem_width),
        .dec_operand1(dec_operand1), .dec_operand2(dec_operand2), .dec_imm(dec_imm),
        .dec_wb_en(dec_wb_en), .dec_legal(dec_legal),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_rd(dec_rd),
        .dec_valid(dec_valid), .dec_ready(dec_ready)
    );

endmodule

// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    // Width of the integer datapath
    localparam int xlen = 64;

    // Width of one instruction word
    localparam int ilen = 32;

    // First address fetched once reset is released
    localparam logic [xlen-1:0] reset_pc = 64'h8000_0000;

    // Major opcodes of the RV64I base set that the decoder accepts
    // All of them end in 2'b11, so compressed encodings never match
    typedef enum logic [6:0] {
        opc_load      = 7'b0000011,
        opc_op_imm    = 7'b0010011,
        opc_auipc     = 7'b0010111,
        opc_op_imm_32 = 7'b0011011,
        opc_store     = 7'b0100011,
        opc_op        = 7'b0110011,
        opc_lui       = 7'b0110111,
        opc_op_32     = 7'b0111011,
        opc_branch    = 7'b1100011,
        opc_jalr      = 7'b1100111,
        opc_jal       = 7'b1101111
    } opcode_e;

    // Instruction class handed to the issue stage
    typedef enum logic [2:0] {
        alu     = 3'd0,
        branch  = 3'd1,
        jump    = 3'd2,
        load    = 3'd3,
        store   = 3'd4,
        illegal = 3'd7
    } op_type_e;

    // ALU function, encoded the same way as funct3
    // For branches the same field carries the compare condition
    typedef enum logic [2:0] {
        add    = 3'd0,
        sll    = 3'd1,
        slt    = 3'd2,
        sltu   = 3'd3,
        xor_op = 3'd4,
        sr     = 3'd5,
        or_op  = 3'd6,
        and_op = 3'd7
    } alu_op_e;

    // Where each ALU operand comes from
    typedef enum logic [1:0] {
        sel_reg  = 2'd0,
        sel_imm  = 2'd1,
        sel_pc   = 2'd2,
        sel_zero = 2'd3
    } operand_sel_e;

    // Kind of control transfer
    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_cond = 2'd1,
        br_jal  = 2'd2,
        br_jalr = 2'd3
    } br_type_e;

endpackage
